// File: hw/udp_frame_pkg.sv
`default_nettype none

package udp_frame_pkg;

    ////////////////////////////////////////////////////////////
    // Field types
    ////////////////////////////////////////////////////////////

    typedef logic [47:0] mac_address_t;
    typedef logic [31:0] ipv4_address_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [7:0]  frame_byte_t;

    // Byte counts and payload buffer addresses
    typedef logic [15:0] length_t;

    ////////////////////////////////////////////////////////////
    // Protocol constants
    ////////////////////////////////////////////////////////////

    localparam logic [15:0] ETHERTYPE_IPV4           = 16'h0800;
    localparam logic [7:0]  IPV4_VERSION_IHL         = 8'h45;
    localparam logic [7:0]  IPV4_TOS                 = 8'h00;
    localparam logic [15:0] IPV4_FLAGS_DONT_FRAGMENT = 16'h4000;
    localparam logic [7:0]  IPV4_TTL                 = 8'h80;
    localparam logic [7:0]  IPV4_PROTOCOL_UDP        = 8'h11;

    // Header lengths in bytes
    localparam length_t IPV4_UDP_HEADER_BYTES = 16'd28;
    localparam length_t UDP_HEADER_BYTES      = 16'd8;
    localparam length_t FRAME_HEADER_BYTES    = 16'd42;

    // Shortest frame on the wire, FCS not included
    localparam length_t MIN_FRAME_BYTES = 16'd60;

    ////////////////////////////////////////////////////////////
    // Ethernet FCS
    ////////////////////////////////////////////////////////////

    localparam logic [31:0] CRC32_POLY_REFLECTED = 32'hEDB88320;
    localparam logic [31:0] CRC32_INIT           = 32'hFFFFFFFF;

endpackage

`default_nettype wire

// File: hw/header_sequencer.sv
`default_nettype none
`timescale 1ns/1ps

module header_sequencer #(
    parameter int INTER_PACKET_GAP_CYCLES = 15
) (
    input  wire                                 clock,
    input  wire                                 reset_n,
    input  wire                                 enable,
    input  wire udp_frame_pkg::mac_address_t    mac_destination,
    input  wire udp_frame_pkg::mac_address_t    mac_source,
    input  wire udp_frame_pkg::ipv4_address_t   ipv4_destination,
    input  wire udp_frame_pkg::ipv4_address_t   ipv4_source,
    input  wire udp_frame_pkg::udp_port_t       udp_destination,
    input  wire udp_frame_pkg::udp_port_t       udp_source,
    input  wire [15:0]                          ipv4_identification,
    input  wire udp_frame_pkg::length_t         payload_size,
    input  wire udp_frame_pkg::frame_byte_t     payload_read_data,
    input  wire                                 full,
    output logic                                ready,
    output udp_frame_pkg::length_t              payload_read_address,
    output logic                                push,
    output udp_frame_pkg::frame_byte_t          push_data,
    output logic                                push_start,
    output logic                                push_last
);

    import udp_frame_pkg::*;

    localparam int IPV4_HEADER_WORDS = 10;
    localparam int HEADER_MSB        = 8 * FRAME_HEADER_BYTES - 1;
    // IPv4 header follows the 14-byte Ethernet header
    localparam int IPV4_WORD_MSB     = HEADER_MSB - 8 * 14;

    typedef enum logic [2:0] {
        S_IDLE,
        S_CHECKSUM,
        S_HEADER,
        S_PAYLOAD,
        S_PAD,
        S_GAP
    } state_t;

    state_t        state;
    logic          accept;
    logic          payload_last;
    length_t       byte_count;
    length_t       payload_index;
    length_t       step_count;
    length_t       saved_payload_size;
    length_t       ipv4_total_length;
    length_t       udp_length;
    mac_address_t  saved_mac_destination;
    mac_address_t  saved_mac_source;
    ipv4_address_t saved_ipv4_destination;
    ipv4_address_t saved_ipv4_source;
    udp_port_t     saved_udp_destination;
    udp_port_t     saved_udp_source;
    logic [15:0]   saved_ipv4_identification;
    logic [15:0]   ipv4_checksum;
    logic [15:0]   checksum_sum;
    logic [15:0]   checksum_word;
    logic [16:0]   checksum_add;
    logic [15:0]   checksum_folded;
    logic [HEADER_MSB:0] header_bits;

    assign accept = (state == S_IDLE) && enable && ready;

    // All 42 header bytes, first byte on the wire in the top bits
    assign header_bits = {saved_mac_destination, saved_mac_source, ETHERTYPE_IPV4,
                          IPV4_VERSION_IHL, IPV4_TOS, ipv4_total_length,
                          saved_ipv4_identification, IPV4_FLAGS_DONT_FRAGMENT,
                          IPV4_TTL, IPV4_PROTOCOL_UDP, ipv4_checksum,
                          saved_ipv4_source, saved_ipv4_destination,
                          saved_udp_source, saved_udp_destination, udp_length, 16'h0000};

    ////////////////////////////////////////////////////////////
    // IPv4 checksum, one header word per cycle
    ////////////////////////////////////////////////////////////

    assign checksum_word   = header_bits[IPV4_WORD_MSB - 16 * int'(step_count[3:0]) -: 16];
    assign checksum_add    = {1'b0, checksum_sum} + {1'b0, checksum_word};
    // End-around carry
    assign checksum_folded = checksum_add[15:0] + {15'd0, checksum_add[16]};

    ////////////////////////////////////////////////////////////
    // Byte emission
    ////////////////////////////////////////////////////////////

    assign payload_last = (payload_index == saved_payload_size - 1'b1);
    assign push         = (state == S_HEADER || state == S_PAYLOAD || state == S_PAD) && !full;
    assign push_start   = (state == S_HEADER) && (byte_count == '0);
    assign push_last    = (state == S_PAYLOAD && payload_last &&
                           byte_count >= MIN_FRAME_BYTES - 1'b1) ||
                          (state == S_PAD && byte_count == MIN_FRAME_BYTES - 1'b1);

    // Next address goes out while the current byte is pushed
    assign payload_read_address = (state == S_PAYLOAD && push && !payload_last) ?
                                  payload_index + 1'b1 : payload_index;

    always_comb begin
        case (state)
            S_HEADER:  push_data = header_bits[HEADER_MSB - 8 * int'(byte_count[5:0]) -: 8];
            S_PAYLOAD: push_data = payload_read_data;
            default:   push_data = '0;
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state         <= S_IDLE;
            ready         <= 1'b0;
            byte_count    <= '0;
            payload_index <= '0;
            step_count    <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    ready <= 1'b1;
                    if (accept) begin
                        ready         <= 1'b0;
                        byte_count    <= '0;
                        payload_index <= '0;
                        step_count    <= '0;
                        state         <= S_CHECKSUM;
                    end
                end
                S_CHECKSUM: begin
                    step_count <= step_count + 1'b1;
                    if (step_count == length_t'(IPV4_HEADER_WORDS - 1)) begin
                        state <= S_HEADER;
                    end
                end
                S_HEADER: begin
                    if (push) begin
                        byte_count <= byte_count + 1'b1;
                        if (byte_count == FRAME_HEADER_BYTES - 1'b1) begin
                            state <= S_PAYLOAD;
                        end
                    end
                end
                S_PAYLOAD: begin
                    if (push) begin
                        byte_count    <= byte_count + 1'b1;
                        payload_index <= payload_index + 1'b1;
                        step_count    <= '0;
                        if (payload_last) begin
                            state <= push_last ? S_GAP : S_PAD;
                        end
                    end
                end
                S_PAD: begin
                    if (push) begin
                        byte_count <= byte_count + 1'b1;
                        if (push_last) begin
                            state <= S_GAP;
                        end
                    end
                end
                default: begin
                    step_count <= step_count + 1'b1;
                    if (step_count == length_t'(INTER_PACKET_GAP_CYCLES - 1)) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // Captured fields and checksum accumulator
    always_ff @(posedge clock) begin
        if (accept) begin
            saved_mac_destination     <= mac_destination;
            saved_mac_source          <= mac_source;
            saved_ipv4_destination    <= ipv4_destination;
            saved_ipv4_source         <= ipv4_source;
            saved_udp_destination     <= udp_destination;
            saved_udp_source          <= udp_source;
            saved_ipv4_identification <= ipv4_identification;
            saved_payload_size        <= payload_size;
            ipv4_total_length         <= payload_size + IPV4_UDP_HEADER_BYTES;
            udp_length                <= payload_size + UDP_HEADER_BYTES;
            ipv4_checksum             <= '0;
            checksum_sum              <= '0;
        end else if (state == S_CHECKSUM) begin
            checksum_sum <= checksum_folded;
            if (step_count == length_t'(IPV4_HEADER_WORDS - 1)) begin
                ipv4_checksum <= ~checksum_folded;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/frame_byte_fifo.sv
`default_nettype none
`timescale 1ns/1ps

module frame_byte_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  wire                             clock,
    input  wire                             reset_n,
    input  wire                             push,
    input  wire udp_frame_pkg::frame_byte_t push_data,
    input  wire                             push_start,
    input  wire                             push_last,
    output logic                            full,
    input  wire                             pop,
    output logic                            empty,
    output udp_frame_pkg::frame_byte_t      pop_data,
    output logic                            pop_start,
    output logic                            pop_last
);

    import udp_frame_pkg::*;

    localparam int POINTER_BITS = $clog2(FIFO_DEPTH);
    // Data byte plus start and last flags
    localparam int ENTRY_BITS   = $bits(frame_byte_t) + 2;

    logic [ENTRY_BITS-1:0]   entries [FIFO_DEPTH];
    logic [POINTER_BITS-1:0] write_pointer;
    logic [POINTER_BITS-1:0] read_pointer;
    logic [POINTER_BITS:0]   count;
    logic                    write_ok;
    logic                    read_ok;

    assign full     = (count == (POINTER_BITS + 1)'(FIFO_DEPTH));
    assign empty    = (count == '0);
    assign write_ok = push && !full;
    assign read_ok  = pop && !empty;

    // Head entry is visible without a pop
    assign {pop_start, pop_last, pop_data} = entries[read_pointer];

    always_ff @(posedge clock) begin
        if (write_ok) begin
            entries[write_pointer] <= {push_start, push_last, push_data};
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            write_pointer <= '0;
            read_pointer  <= '0;
            count         <= '0;
        end else begin
            if (write_ok) begin
                write_pointer <= (write_pointer == POINTER_BITS'(FIFO_DEPTH - 1)) ?
                                 '0 : write_pointer + 1'b1;
            end
            if (read_ok) begin
                read_pointer <= (read_pointer == POINTER_BITS'(FIFO_DEPTH - 1)) ?
                                '0 : read_pointer + 1'b1;
            end
            count <= count + write_ok - read_ok;
        end
    end

endmodule

`default_nettype wire

// File: hw/fcs_appender.sv
`default_nettype none
`timescale 1ns/1ps

module fcs_appender (
    input  wire                             clock,
    input  wire                             reset_n,
    input  wire                             empty,
    input  wire udp_frame_pkg::frame_byte_t pop_data,
    input  wire                             pop_start,
    input  wire                             pop_last,
    output logic                            pop,
    output udp_frame_pkg::frame_byte_t      frame_data,
    output logic                            frame_valid,
    output logic                            frame_start,
    output logic                            frame_last
);

    import udp_frame_pkg::*;

    localparam logic [2:0] FCS_BYTES = 3'd4;

    logic [2:0]  fcs_count;
    logic [31:0] crc;

    // Bytewise update, reflected polynomial, LSB first
    function automatic logic [31:0] crc32_byte(input logic [31:0] crc_in,
                                               input frame_byte_t data);
        logic [31:0] value;
        value = crc_in ^ {24'h000000, data};
        for (int bit_index = 0; bit_index < 8; bit_index++) begin
            if (value[0]) begin
                value = (value >> 1) ^ CRC32_POLY_REFLECTED;
            end else begin
                value = value >> 1;
            end
        end
        return value;
    endfunction

    // FIFO holds while the FCS goes out
    assign pop = !empty && (fcs_count == '0);

    ////////////////////////////////////////////////////////////
    // Output byte and CRC register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (pop) begin
            frame_data <= pop_data;
            crc        <= crc32_byte(pop_start ? CRC32_INIT : crc, pop_data);
        end else if (fcs_count != '0) begin
            frame_data <= ~crc[7:0];
            // Next FCS byte moves down
            crc        <= crc >> 8;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            fcs_count   <= '0;
            frame_valid <= 1'b0;
            frame_start <= 1'b0;
            frame_last  <= 1'b0;
        end else begin
            frame_valid <= pop || (fcs_count != '0);
            frame_start <= pop && pop_start;
            frame_last  <= (fcs_count == 3'd1);
            if (pop && pop_last) begin
                fcs_count <= FCS_BYTES;
            end else if (fcs_count != '0) begin
                fcs_count <= fcs_count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/udp_frame_generator.sv
`default_nettype none
`timescale 1ns/1ps

module udp_frame_generator #(
    parameter int INTER_PACKET_GAP_CYCLES = 15,
    parameter int FIFO_DEPTH              = 8
) (
    input  wire                                 clock,
    input  wire                                 reset_n,
    input  wire                                 enable,
    input  wire udp_frame_pkg::mac_address_t    mac_destination,
    input  wire udp_frame_pkg::mac_address_t    mac_source,
    input  wire udp_frame_pkg::ipv4_address_t   ipv4_destination,
    input  wire udp_frame_pkg::ipv4_address_t   ipv4_source,
    input  wire udp_frame_pkg::udp_port_t       udp_destination,
    input  wire udp_frame_pkg::udp_port_t       udp_source,
    input  wire [15:0]                          ipv4_identification,
    input  wire udp_frame_pkg::length_t         payload_size,
    input  wire udp_frame_pkg::frame_byte_t     payload_read_data,
    output logic                                ready,
    output udp_frame_pkg::length_t              payload_read_address,
    output udp_frame_pkg::frame_byte_t          frame_data,
    output logic                                frame_valid,
    output logic                                frame_start,
    output logic                                frame_last
);

    import udp_frame_pkg::*;

    logic        push;
    frame_byte_t push_data;
    logic        push_start;
    logic        push_last;
    logic        full;
    logic        pop;
    logic        empty;
    frame_byte_t pop_data;
    logic        pop_start;
    logic        pop_last;

    ////////////////////////////////////////////////////////////
    // Header sequencer, byte FIFO, FCS appender
    ////////////////////////////////////////////////////////////

    header_sequencer #(
        .INTER_PACKET_GAP_CYCLES (INTER_PACKET_GAP_CYCLES)
    ) header_sequencer_i (
        .clock                (clock),
        .reset_n              (reset_n),
        .enable               (enable),
        .mac_destination      (mac_destination),
        .mac_source           (mac_source),
        .ipv4_destination     (ipv4_destination),
        .ipv4_source          (ipv4_source),
        .udp_destination      (udp_destination),
        .udp_source           (udp_source),
        .ipv4_identification  (ipv4_identification),
        .payload_size         (payload_size),
        .payload_read_data    (payload_read_data),
        .full                 (full),
        .ready                (ready),
        .payload_read_address (payload_read_address),
        .push                 (push),
        .push_data            (push_data),
        .push_start           (push_start),
        .push_last            (push_last)
    );

    frame_byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) frame_byte_fifo_i (
        .clock      (clock),
        .reset_n    (reset_n),
        .push       (push),
        .push_data  (push_data),
        .push_start (push_start),
        .push_last  (push_last),
        .full       (full),
        .pop        (pop),
        .empty      (empty),
        .pop_data   (pop_data),
        .pop_start  (pop_start),
        .pop_last   (pop_last)
    );

    fcs_appender fcs_appender_i (
        .clock       (clock),
        .reset_n     (reset_n),
        .empty       (empty),
        .pop_data    (pop_data),
        .pop_start   (pop_start),
        .pop_last    (pop_last),
        .pop         (pop),
        .frame_data  (frame_data),
        .frame_valid (frame_valid),
        .frame_start (frame_start),
        .frame_last  (frame_last)
    );

endmodule

`default_nettype wire

// File: bench/frame_clock_gen.sv
`default_nettype none
`timescale 1ns/1ps

module frame_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic clock,
    output logic reset_n
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    // Released on a falling edge
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: bench/udp_frame_assertions.sv
`default_nettype none
`timescale 1ns/1ps

module udp_frame_assertions (
    input wire clock,
    input wire reset_n,
    input wire enable,
    input wire ready,
    input wire frame_valid,
    input wire frame_start,
    input wire frame_last
);

    int   failure_count = 0;
    logic in_frame;
    logic busy;

    // Frame open after frame_start, closed after frame_last
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            in_frame <= 1'b0;
            busy     <= 1'b0;
        end else begin
            in_frame <= (frame_start || in_frame) && !frame_last;
            if (enable && ready) begin
                busy <= 1'b1;
            end else if (frame_last) begin
                busy <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Output framing
    ////////////////////////////////////////////////////////////

    reset_release: assert property (@(posedge clock) $rose(reset_n) |-> !frame_valid ##1 ready)
        else begin $error("no idle output or no ready after reset"); failure_count++; end

    start_valid: assert property (@(posedge clock) disable iff (!reset_n)
        frame_start |-> frame_valid)
        else begin $error("frame_start without frame_valid"); failure_count++; end

    last_valid: assert property (@(posedge clock) disable iff (!reset_n)
        frame_last |-> frame_valid)
        else begin $error("frame_last without frame_valid"); failure_count++; end

    valid_held: assert property (@(posedge clock) disable iff (!reset_n)
        (frame_start || in_frame) |-> frame_valid)
        else begin $error("frame_valid dropped inside a frame"); failure_count++; end

    single_start: assert property (@(posedge clock) disable iff (!reset_n)
        in_frame |-> !frame_start)
        else begin $error("second frame_start before frame_last"); failure_count++; end

    last_closes: assert property (@(posedge clock) disable iff (!reset_n)
        frame_last |-> (frame_start || in_frame))
        else begin $error("frame_last outside a frame"); failure_count++; end

    ready_held: assert property (@(posedge clock) disable iff (!reset_n)
        busy |-> !ready)
        else begin $error("ready high before the frame ended"); failure_count++; end

endmodule

`default_nettype wire

// File: bench/udp_frame_generator_tb.sv
`default_nettype none
`timescale 1ns/1ps

module udp_frame_generator_tb;

    import udp_frame_pkg::*;

    localparam int GAP_CYCLES      = 15;
    localparam int FIFO_DEPTH      = 8;
    localparam int CLOCK_PERIOD_NS = 40;
    localparam int RANDOM_SEED     = 88128;
    localparam int FRAME_COUNT     = 5;
    // Last two go out back to back
    localparam int PAYLOAD_SIZES [FRAME_COUNT] = '{5, 18, 100, 30, 64};

    logic          clock;
    logic          reset_n;
    logic          enable;
    mac_address_t  mac_destination;
    mac_address_t  mac_source;
    ipv4_address_t ipv4_destination;
    ipv4_address_t ipv4_source;
    udp_port_t     udp_destination;
    udp_port_t     udp_source;
    logic [15:0]   ipv4_identification;
    length_t       payload_size;
    frame_byte_t   payload_read_data;
    logic          ready;
    length_t       payload_read_address;
    frame_byte_t   frame_data;
    logic          frame_valid;
    logic          frame_start;
    logic          frame_last;

    length_t       read_address_held = '0;
    frame_byte_t   expected[$];
    frame_byte_t   expected_frames [FRAME_COUNT][$];
    frame_byte_t   received[$];
    int            frames_done   = 0;
    int            check_errors  = 0;
    int            tests_passed  = 0;
    int            tests_failed  = 0;
    int            errors_before = 0;

    frame_clock_gen #(
        .PERIOD_NS    (CLOCK_PERIOD_NS),
        .RESET_CYCLES (10)
    ) clock_gen_i (
        .clock   (clock),
        .reset_n (reset_n)
    );

    udp_frame_generator #(
        .INTER_PACKET_GAP_CYCLES (GAP_CYCLES),
        .FIFO_DEPTH              (FIFO_DEPTH)
    ) dut_i (
        .clock                (clock),
        .reset_n              (reset_n),
        .enable               (enable),
        .mac_destination      (mac_destination),
        .mac_source           (mac_source),
        .ipv4_destination     (ipv4_destination),
        .ipv4_source          (ipv4_source),
        .udp_destination      (udp_destination),
        .udp_source           (udp_source),
        .ipv4_identification  (ipv4_identification),
        .payload_size         (payload_size),
        .payload_read_data    (payload_read_data),
        .ready                (ready),
        .payload_read_address (payload_read_address),
        .frame_data           (frame_data),
        .frame_valid          (frame_valid),
        .frame_start          (frame_start),
        .frame_last           (frame_last)
    );

    bind udp_frame_generator udp_frame_assertions assertions_i (
        .clock       (clock),
        .reset_n     (reset_n),
        .enable      (enable),
        .ready       (ready),
        .frame_valid (frame_valid),
        .frame_start (frame_start),
        .frame_last  (frame_last)
    );

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [15:0] header_word_sum(input frame_byte_t bytes[$]);
        logic [31:0] sum;
        sum = '0;
        for (int i = 14; i < 34; i += 2) begin
            sum += {16'h0000, bytes[i], bytes[i + 1]};
        end
        sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
        sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
        return sum[15:0];
    endfunction

    // Bit-serial CRC-32 taking data LSB first
    function automatic logic [31:0] fcs_of(input frame_byte_t bytes[$]);
        logic [31:0] crc;
        logic        feedback;
        crc = CRC32_INIT;
        foreach (bytes[i]) begin
            for (int b = 0; b < 8; b++) begin
                feedback = crc[0] ^ bytes[i][b];
                crc      = crc >> 1;
                if (feedback) begin
                    crc = crc ^ CRC32_POLY_REFLECTED;
                end
            end
        end
        return ~crc;
    endfunction

    task automatic append_field(input logic [47:0] value, input int count);
        for (int i = count - 1; i >= 0; i--) begin
            expected.push_back(value[8 * i +: 8]);
        end
    endtask

    task automatic build_reference(input int index);
        logic [15:0] checksum;
        logic [31:0] fcs;
        expected.delete();
        append_field(mac_destination, 6);
        append_field(mac_source, 6);
        append_field(48'(ETHERTYPE_IPV4), 2);
        append_field(48'({IPV4_VERSION_IHL, IPV4_TOS}), 2);
        append_field(48'(payload_size + IPV4_UDP_HEADER_BYTES), 2);
        append_field(48'(ipv4_identification), 2);
        append_field(48'(IPV4_FLAGS_DONT_FRAGMENT), 2);
        append_field(48'({IPV4_TTL, IPV4_PROTOCOL_UDP}), 2);
        // Checksum slot stays zero while summing
        append_field(48'h0, 2);
        append_field(48'(ipv4_source), 4);
        append_field(48'(ipv4_destination), 4);
        append_field(48'(udp_source), 2);
        append_field(48'(udp_destination), 2);
        append_field(48'(payload_size + UDP_HEADER_BYTES), 2);
        append_field(48'h0, 2);
        checksum     = ~header_word_sum(expected);
        expected[24] = checksum[15:8];
        expected[25] = checksum[7:0];
        for (int k = 0; k < int'(payload_size); k++) begin
            expected.push_back(8'(k) ^ 8'h5A);
        end
        while (expected.size() < int'(MIN_FRAME_BYTES)) begin
            expected.push_back(8'h00);
        end
        fcs = fcs_of(expected);
        for (int k = 0; k < 4; k++) begin
            expected.push_back(fcs[8 * k +: 8]);
        end
        expected_frames[index] = expected;
    endtask

    ////////////////////////////////////////////////////////////
    // Payload buffer and frame collector
    ////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        payload_read_data <= read_address_held[7:0] ^ 8'h5A;
        read_address_held <= payload_read_address;
    end

    task automatic check_frame();
        frame_byte_t reference[$];
        if (frames_done >= FRAME_COUNT) begin
            $display("Frame %0d came out but no such frame was sent", frames_done);
            check_errors++;
            return;
        end
        reference = expected_frames[frames_done];
        assert (received.size() == reference.size()) else begin
            $display("FAIL frame length: got 0x%0h, expected 0x%0h",
                     received.size(), reference.size());
            check_errors++;
        end
        for (int i = 0; i < received.size() && i < reference.size(); i++) begin
            assert (received[i] == reference[i]) else begin
                $display("FAIL frame_data[%0d]: got 0x%02h, expected 0x%02h",
                         i, received[i], reference[i]);
                check_errors++;
            end
        end
        if (received.size() >= 34) begin
            assert (header_word_sum(received) == 16'hFFFF) else begin
                $display("FAIL ipv4 header sum: got 0x%04h, expected 0xffff",
                         header_word_sum(received));
                check_errors++;
            end
        end
    endtask

    always @(negedge clock) begin
        if (reset_n && frame_valid) begin
            if (frame_start) begin
                received.delete();
            end
            received.push_back(frame_data);
            if (frame_last) begin
                check_frame();
                frames_done++;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    function automatic int total_errors();
        return check_errors + dut_i.assertions_i.failure_count;
    endfunction

    // Called on a falling edge and returns after the accepting edge
    task automatic send_frame(input int index);
        mac_destination     = {16'($urandom()), $urandom()};
        mac_source          = {16'($urandom()), $urandom()};
        ipv4_destination    = $urandom();
        ipv4_source         = $urandom();
        udp_destination     = 16'($urandom());
        udp_source          = 16'($urandom());
        ipv4_identification = 16'($urandom());
        payload_size        = length_t'(PAYLOAD_SIZES[index]);
        enable              = 1'b1;
        build_reference(index);
        while (!ready) @(negedge clock);
        @(negedge clock);
    endtask

    task automatic wait_frames(input int count);
        while (frames_done < count) @(negedge clock);
    endtask

    task automatic finish_test(input string name);
        int errors;
        errors = total_errors() - errors_before;
        if (errors == 0) begin
            tests_passed++;
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors);
        end
        errors_before = total_errors();
    endtask

    initial begin
        void'($urandom(RANDOM_SEED));
        enable              = 1'b0;
        mac_destination     = '0;
        mac_source          = '0;
        ipv4_destination    = '0;
        ipv4_source         = '0;
        udp_destination     = '0;
        udp_source          = '0;
        ipv4_identification = '0;
        payload_size        = '0;
        payload_read_data   = '0;
        @(posedge reset_n);
        @(negedge clock);

        send_frame(0);
        enable = 1'b0;
        wait_frames(1);
        finish_test("padded payload 5");

        send_frame(1);
        enable = 1'b0;
        wait_frames(2);
        finish_test("unpadded payload 18");

        send_frame(2);
        enable = 1'b0;
        wait_frames(3);
        finish_test("long payload 100");

        // enable stays high across both acceptances
        send_frame(3);
        send_frame(4);
        enable = 1'b0;
        wait_frames(5);
        finish_test("back to back 30 and 64");

        while (!ready) @(negedge clock);
        $display("%0d tests: %0d passed, %0d failed, %0d check errors, %0d assertion failures",
                 tests_passed + tests_failed, tests_passed, tests_failed,
                 check_errors, dut_i.assertions_i.failure_count);
        if (total_errors() == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    function automatic longint watchdog_ns();
        longint cycles;
        cycles = 0;
        for (int i = 0; i < FRAME_COUNT; i++) begin
            cycles += PAYLOAD_SIZES[i] + int'(MIN_FRAME_BYTES) + GAP_CYCLES + 20;
        end
        return 2 * cycles * CLOCK_PERIOD_NS;
    endfunction

    initial begin
        #(watchdog_ns());
        $display("Watchdog expired before all frames were checked");
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: udp_frame_generator.f
hw/udp_frame_pkg.sv
hw/header_sequencer.sv
hw/frame_byte_fifo.sv
hw/fcs_appender.sv
hw/udp_frame_generator.sv
bench/frame_clock_gen.sv
bench/udp_frame_assertions.sv
bench/udp_frame_generator_tb.sv

// File: Bender.yml
package:
  name: udp_frame_generator

sources:
  - hw/udp_frame_pkg.sv
  - hw/header_sequencer.sv
  - hw/frame_byte_fifo.sv
  - hw/fcs_appender.sv
  - hw/udp_frame_generator.sv
  - target: test
    files:
      - bench/frame_clock_gen.sv
      - bench/udp_frame_assertions.sv
      - bench/udp_frame_generator_tb.sv
